// ==== rtl/rv32_pkg.sv ====
// ####################################################################
// Widths, opcode and funct3 encodings, ALU and operand-select enums.
// ####################################################################
`default_nettype none

package rv32_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010; // LW and SW width.

    localparam logic [xlen-1:0] nop_word  = 32'h0000_0013; // ADDI x0,x0,0.
    localparam logic [3:0]      word_mask = 4'b1111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_res,
        fwd_none
    } fwd_sel_t;

endpackage : rv32_pkg

`default_nettype wire

// ==== rtl/rv32_stall.sv ====
// ####################################################################
// Outstanding memory request tracking and the global move strobe.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_stall (
    input  logic clk,
    input  logic arst_n,
    input  logic imem_req,
    input  logic dmem_req,
    input  logic imem_resp,
    input  logic dmem_resp,
    output logic move
);

    logic imem_done;
    logic dmem_done;

    // Fetch requests every cycle after a move, so move always waits for it.
    assign move = (imem_done || (imem_req && imem_resp)) &&
                  (!dmem_req || dmem_done || dmem_resp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else if (move) begin
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else begin
            imem_done <= imem_done || (imem_req && imem_resp); // Early answer.
            dmem_done <= dmem_done || (dmem_req && dmem_resp);
        end
    end

    a_resp_has_req : assert property (@(posedge clk) disable iff (!arst_n)
        (imem_resp |-> imem_req) and (dmem_resp |-> dmem_req));

endmodule : rv32_stall

`default_nettype wire

// ==== rtl/rv32_fetch.sv ====
// ####################################################################
// Program counter, instruction request and the fetch-to-decode word.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_fetch (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     move,
    output logic                     imem_req,
    output logic [rv32_pkg::xlen-1:0] imem_addr,
    output logic [3:0]               imem_rmask,
    input  logic                     imem_resp,
    input  logic [rv32_pkg::xlen-1:0] imem_rdata,
    output logic [rv32_pkg::xlen-1:0] pc,
    output logic [rv32_pkg::xlen-1:0] instr
);
    import rv32_pkg::*;

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] rdata_q;
    logic            live;
    logic            got;

    assign imem_req   = live && !got;
    assign imem_addr  = pc_q;
    assign imem_rmask = imem_req ? word_mask : 4'b0000;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live  <= 1'b0;
            got   <= 1'b0;
            pc_q  <= '0;
            pc    <= '0;
            instr <= nop_word;
        end else begin
            live <= 1'b1; // First request goes out on the first edge.
            if (move) begin
                got   <= 1'b0;
                pc_q  <= pc_q + xlen'(4);
                pc    <= pc_q;
                instr <= imem_resp ? imem_rdata : rdata_q;
            end else if (imem_resp) begin
                got <= 1'b1;
            end
        end
    end

    // Word may come back before the data side is done.
    always_ff @(posedge clk) begin
        if (imem_resp)
            rdata_q <= imem_rdata;
    end

    a_addr_stable : assert property (@(posedge clk) disable iff (!arst_n)
        imem_req && !imem_resp |=> $stable(imem_addr));

endmodule : rv32_fetch

`default_nettype wire

// ==== rtl/rv32_regfile.sv ====
// ####################################################################
// Register file, x0 tied to zero, reads see the write in flight.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           regf_we,
    input  logic [rv32_pkg::reg_addr_w-1:0] rd_sel,
    input  logic [rv32_pkg::reg_addr_w-1:0] rs1_s,
    input  logic [rv32_pkg::reg_addr_w-1:0] rs2_s,
    input  logic [rv32_pkg::xlen-1:0]       rd_v,
    output logic [rv32_pkg::xlen-1:0]       rs1_v,
    output logic [rv32_pkg::xlen-1:0]       rs2_v
);
    import rv32_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wr;

    assign wr = regf_we && (rd_sel != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr) begin
            regs[rd_sel] <= rd_v;
        end
    end

    assign rs1_v = (wr && rs1_s == rd_sel) ? rd_v : regs[rs1_s];
    assign rs2_v = (wr && rs2_s == rd_sel) ? rd_v : regs[rs2_s];

endmodule : rv32_regfile

`default_nettype wire

// ==== rtl/rv32_decode.sv ====
// ####################################################################
// Instruction decode, immediate build and the decode-to-execute register.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_decode (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           move,
    input  logic [rv32_pkg::xlen-1:0]       instr,
    output logic [rv32_pkg::reg_addr_w-1:0] rs1_s,
    output logic [rv32_pkg::reg_addr_w-1:0] rs2_s,
    input  logic [rv32_pkg::xlen-1:0]       rs1_v,
    input  logic [rv32_pkg::xlen-1:0]       rs2_v,
    output logic [rv32_pkg::reg_addr_w-1:0] x_rs1_s,
    output logic [rv32_pkg::reg_addr_w-1:0] x_rs2_s,
    output logic [rv32_pkg::reg_addr_w-1:0] x_rd,
    output logic [rv32_pkg::xlen-1:0]       x_rs1_v,
    output logic [rv32_pkg::xlen-1:0]       x_rs2_v,
    output logic [rv32_pkg::xlen-1:0]       x_imm,
    output rv32_pkg::alu_op_t               x_alu_op,
    output logic                           x_use_imm,
    output logic                           x_reg_write,
    output logic                           x_mem_read,
    output logic                           x_mem_write
);
    import rv32_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic            f7b5;
    logic [xlen-1:0] imm;
    alu_op_t         alu_op;
    logic            use_imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7b5   = instr[30];
    assign rs1_s  = instr[19:15];
    assign rs2_s  = instr[24:20];

    always_comb begin
        imm       = {{20{instr[31]}}, instr[31:20]}; // I-type by default.
        alu_op    = alu_add;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (opcode)
            op_reg, op_imm: begin
                use_imm   = (opcode == op_imm);
                reg_write = 1'b1;
                case (f3)
                    f3_add_sub: alu_op = (!use_imm && f7b5) ? alu_sub : alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = f7b5 ? alu_sra : alu_srl; // SRAI too.
                    f3_or:      alu_op = alu_or;
                    default:    alu_op = alu_and;
                endcase
            end
            op_lui: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = alu_pass_b;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            op_load: begin
                use_imm   = 1'b1;
                reg_write = (f3 == f3_word);
                mem_read  = (f3 == f3_word);
            end
            op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                mem_write = (f3 == f3_word);
            end
            default: ; // Unsupported opcodes run as no-ops.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_rs1_s     <= '0;
            x_rs2_s     <= '0;
            x_rd        <= '0;
            x_rs1_v     <= '0;
            x_rs2_v     <= '0;
            x_imm       <= '0;
            x_alu_op    <= alu_add;
            x_use_imm   <= 1'b1;
            x_reg_write <= 1'b0;
            x_mem_read  <= 1'b0;
            x_mem_write <= 1'b0;
        end else if (move) begin
            x_rs1_s     <= rs1_s;
            x_rs2_s     <= rs2_s;
            x_rd        <= instr[11:7];
            x_rs1_v     <= rs1_v;
            x_rs2_v     <= rs2_v;
            x_imm       <= imm;
            x_alu_op    <= alu_op;
            x_use_imm   <= use_imm;
            x_reg_write <= reg_write;
            x_mem_read  <= mem_read;
            x_mem_write <= mem_write;
        end
    end

endmodule : rv32_decode

`default_nettype wire

// ==== rtl/rv32_execute.sv ====
// ####################################################################
// Operand forwarding, ALU and the execute-to-result register.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_execute (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           move,
    input  logic [rv32_pkg::reg_addr_w-1:0] x_rs1_s,
    input  logic [rv32_pkg::reg_addr_w-1:0] x_rs2_s,
    input  logic [rv32_pkg::reg_addr_w-1:0] x_rd,
    input  logic [rv32_pkg::xlen-1:0]       x_rs1_v,
    input  logic [rv32_pkg::xlen-1:0]       x_rs2_v,
    input  logic [rv32_pkg::xlen-1:0]       x_imm,
    input  rv32_pkg::alu_op_t               x_alu_op,
    input  logic                           x_use_imm,
    input  logic                           x_reg_write,
    input  logic                           x_mem_read,
    input  logic                           x_mem_write,
    input  logic                           fwd_valid,
    input  logic [rv32_pkg::reg_addr_w-1:0] fwd_rd,
    input  logic [rv32_pkg::xlen-1:0]       fwd_v,
    output logic [rv32_pkg::xlen-1:0]       r_alu,
    output logic [rv32_pkg::xlen-1:0]       r_store,
    output logic [rv32_pkg::reg_addr_w-1:0] r_rd,
    output logic                           r_reg_write,
    output logic                           r_mem_read,
    output logic                           r_mem_write
);
    import rv32_pkg::*;

    fwd_sel_t        sel_a;
    fwd_sel_t        sel_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b_reg;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_y;

    function automatic fwd_sel_t pick(input logic [reg_addr_w-1:0] src, input logic valid,
        input logic [reg_addr_w-1:0] rd);
        if (src == '0)
            return fwd_none;
        if (valid && rd == src)
            return fwd_res;
        return fwd_reg;
    endfunction

    assign sel_a = pick(x_rs1_s, fwd_valid, fwd_rd);
    assign sel_b = pick(x_rs2_s, fwd_valid, fwd_rd);

    assign op_a     = (sel_a == fwd_res) ? fwd_v : (sel_a == fwd_reg) ? x_rs1_v : '0;
    assign op_b_reg = (sel_b == fwd_res) ? fwd_v : (sel_b == fwd_reg) ? x_rs2_v : '0;
    assign op_b     = x_use_imm ? x_imm : op_b_reg;

    always_comb begin
        case (x_alu_op)
            alu_sub:    alu_y = op_a - op_b;
            alu_sll:    alu_y = op_a << op_b[4:0];
            alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_y = {31'b0, op_a < op_b};
            alu_xor:    alu_y = op_a ^ op_b;
            alu_srl:    alu_y = op_a >> op_b[4:0];
            alu_sra:    alu_y = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     alu_y = op_a | op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_pass_b: alu_y = op_b; // LUI.
            default:    alu_y = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_reg_write <= 1'b0;
            r_mem_read  <= 1'b0;
            r_mem_write <= 1'b0;
        end else if (move) begin
            r_reg_write <= x_reg_write;
            r_mem_read  <= x_mem_read;
            r_mem_write <= x_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            r_alu   <= alu_y;
            r_store <= op_b_reg; // Store data follows the same forwarding.
            r_rd    <= x_rd;
        end
    end

    // Forwarded value is settled whenever the stage registers load.
    a_fwd_known : assert property (@(posedge clk) disable iff (!arst_n)
        move && (sel_a == fwd_res || sel_b == fwd_res) |-> !$isunknown(fwd_v));

endmodule : rv32_execute

`default_nettype wire

// ==== rtl/rv32_result.sv ====
// ####################################################################
// Data memory access, load return, writeback and forwarding source.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_result (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           move,
    input  logic [rv32_pkg::xlen-1:0]       r_alu,
    input  logic [rv32_pkg::xlen-1:0]       r_store,
    input  logic [rv32_pkg::reg_addr_w-1:0] r_rd,
    input  logic                           r_reg_write,
    input  logic                           r_mem_read,
    input  logic                           r_mem_write,
    output logic                           dmem_req,
    output logic [rv32_pkg::xlen-1:0]       dmem_addr,
    output logic [3:0]                     dmem_rmask,
    output logic [3:0]                     dmem_wmask,
    output logic [rv32_pkg::xlen-1:0]       dmem_wdata,
    input  logic [rv32_pkg::xlen-1:0]       dmem_rdata,
    input  logic                           dmem_resp,
    output logic                           regf_we,
    output logic [rv32_pkg::reg_addr_w-1:0] rd_sel,
    output logic [rv32_pkg::xlen-1:0]       rd_v,
    output logic                           fwd_valid,
    output logic [rv32_pkg::reg_addr_w-1:0] fwd_rd,
    output logic [rv32_pkg::xlen-1:0]       fwd_v
);
    import rv32_pkg::*;

    logic            d_done;
    logic [xlen-1:0] load_q;
    logic [xlen-1:0] load_v;

    assign dmem_req   = (r_mem_read || r_mem_write) && !d_done;
    assign dmem_addr  = {r_alu[xlen-1:2], 2'b00};
    assign dmem_rmask = (dmem_req && r_mem_read) ? word_mask : 4'b0000;
    assign dmem_wmask = (dmem_req && r_mem_write) ? word_mask : 4'b0000;
    assign dmem_wdata = r_store;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            d_done <= 1'b0;
        else if (move)
            d_done <= 1'b0;
        else if (dmem_resp)
            d_done <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (dmem_resp)
            load_q <= dmem_rdata;
    end

    assign load_v    = dmem_resp ? dmem_rdata : load_q;
    assign rd_v      = r_mem_read ? load_v : r_alu;
    assign rd_sel    = r_rd;
    assign regf_we   = r_reg_write && move;
    assign fwd_valid = r_reg_write;
    assign fwd_rd    = r_rd;
    assign fwd_v     = rd_v;

    a_one_mask : assert property (@(posedge clk) disable iff (!arst_n)
        !((|dmem_rmask) && (|dmem_wmask)));

endmodule : rv32_result

`default_nettype wire

// ==== rtl/rv32_core.sv ====
// ####################################################################
// Core top: stages, stall unit and register file.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input  logic                     clk,
    input  logic                     arst_n,
    output logic [rv32_pkg::xlen-1:0] imem_addr,
    output logic [3:0]               imem_rmask,
    input  logic [rv32_pkg::xlen-1:0] imem_rdata,
    input  logic                     imem_resp,
    output logic [rv32_pkg::xlen-1:0] dmem_addr,
    output logic [3:0]               dmem_rmask,
    output logic [3:0]               dmem_wmask,
    output logic [rv32_pkg::xlen-1:0] dmem_wdata,
    input  logic [rv32_pkg::xlen-1:0] dmem_rdata,
    input  logic                     dmem_resp
);
    import rv32_pkg::*;

    logic                  move;
    logic                  imem_req;
    logic                  dmem_req;
    logic [xlen-1:0]       instr;
    logic [reg_addr_w-1:0] rs1_s, rs2_s;
    logic [xlen-1:0]       rs1_v, rs2_v;
    logic [reg_addr_w-1:0] x_rs1_s, x_rs2_s, x_rd;
    logic [xlen-1:0]       x_rs1_v, x_rs2_v, x_imm;
    alu_op_t               x_alu_op;
    logic                  x_use_imm, x_reg_write, x_mem_read, x_mem_write;
    logic [xlen-1:0]       r_alu, r_store;
    logic [reg_addr_w-1:0] r_rd;
    logic                  r_reg_write, r_mem_read, r_mem_write;
    logic                  regf_we;
    logic [reg_addr_w-1:0] rd_sel;
    logic [xlen-1:0]       rd_v;
    logic                  fwd_valid;
    logic [reg_addr_w-1:0] fwd_rd;
    logic [xlen-1:0]       fwd_v;

    rv32_stall rv32_stall_i (
        .clk(clk), .arst_n(arst_n),
        .imem_req(imem_req), .dmem_req(dmem_req),
        .imem_resp(imem_resp), .dmem_resp(dmem_resp),
        .move(move)
    );

    rv32_fetch rv32_fetch_i (
        .clk(clk), .arst_n(arst_n), .move(move),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_resp(imem_resp), .imem_rdata(imem_rdata),
        .pc(), // Decode-stage PC, for waveform tracing only.
        .instr(instr)
    );

    rv32_regfile rv32_regfile_i (
        .clk(clk), .arst_n(arst_n),
        .regf_we(regf_we), .rd_sel(rd_sel), .rd_v(rd_v),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .rs1_v(rs1_v), .rs2_v(rs2_v)
    );

    rv32_decode rv32_decode_i (
        .clk(clk), .arst_n(arst_n), .move(move), .instr(instr),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .rs1_v(rs1_v), .rs2_v(rs2_v),
        .x_rs1_s(x_rs1_s), .x_rs2_s(x_rs2_s), .x_rd(x_rd),
        .x_rs1_v(x_rs1_v), .x_rs2_v(x_rs2_v), .x_imm(x_imm),
        .x_alu_op(x_alu_op), .x_use_imm(x_use_imm), .x_reg_write(x_reg_write),
        .x_mem_read(x_mem_read), .x_mem_write(x_mem_write)
    );

    rv32_execute rv32_execute_i (
        .clk(clk), .arst_n(arst_n), .move(move),
        .x_rs1_s(x_rs1_s), .x_rs2_s(x_rs2_s), .x_rd(x_rd),
        .x_rs1_v(x_rs1_v), .x_rs2_v(x_rs2_v), .x_imm(x_imm),
        .x_alu_op(x_alu_op), .x_use_imm(x_use_imm), .x_reg_write(x_reg_write),
        .x_mem_read(x_mem_read), .x_mem_write(x_mem_write),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_v(fwd_v),
        .r_alu(r_alu), .r_store(r_store), .r_rd(r_rd),
        .r_reg_write(r_reg_write), .r_mem_read(r_mem_read), .r_mem_write(r_mem_write)
    );

    rv32_result rv32_result_i (
        .clk(clk), .arst_n(arst_n), .move(move),
        .r_alu(r_alu), .r_store(r_store), .r_rd(r_rd),
        .r_reg_write(r_reg_write), .r_mem_read(r_mem_read), .r_mem_write(r_mem_write),
        .dmem_req(dmem_req), .dmem_addr(dmem_addr),
        .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp),
        .regf_we(regf_we), .rd_sel(rd_sel), .rd_v(rd_v),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_v(fwd_v)
    );

endmodule : rv32_core

`default_nettype wire

// ==== verification/rv32_mem_model.sv ====
// ####################################################################
// Instruction and data memory model with random response latency.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_model (
    input  logic        clk,
    input  logic [31:0] imem_addr,
    input  logic [3:0]  imem_rmask,
    output logic [31:0] imem_rdata,
    output logic        imem_resp,
    input  logic [31:0] dmem_addr,
    input  logic [3:0]  dmem_rmask,
    input  logic [3:0]  dmem_wmask,
    input  logic [31:0] dmem_wdata,
    output logic [31:0] dmem_rdata,
    output logic        dmem_resp
);
    import rv32_pkg::*;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    int          rom_len = 0;
    logic [31:0] rng = 32'd53515;
    int          i_wait = 0; // Cycles left on the open fetch.
    int          d_wait = 0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int next_latency();
        rng = xorshift(rng);
        return 1 + int'(rng % 4);
    endfunction

    task automatic load_word(input int idx, input logic [31:0] word);
        if (idx < 64) begin
            rom[idx] = word;
            if (idx >= rom_len)
                rom_len = idx + 1;
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < rom_len)
            return rom[addr[7:2]];
        return nop_word; // Past the program end.
    endfunction

    initial begin
        imem_rdata = '0;
        imem_resp  = 1'b0;
        dmem_rdata = '0;
        dmem_resp  = 1'b0;
        for (int i = 0; i < 64; i++)
            ram[i] = 32'h5a00_0000 ^ (i * 32'h0001_0004);
    end

    always @(posedge clk) begin
        bit i_fire;
        bit d_fire;
        i_fire = 1'b0;
        d_fire = 1'b0;
        if (!imem_resp) begin // A response in the last cycle closes the request.
            if (i_wait == 0 && imem_rmask != 4'b0000)
                i_wait = next_latency();
            if (i_wait > 0) begin
                i_wait--;
                i_fire = (i_wait == 0);
            end
        end
        if (!dmem_resp) begin
            if (d_wait == 0 && (dmem_rmask != 4'b0000 || dmem_wmask != 4'b0000))
                d_wait = next_latency();
            if (d_wait > 0) begin
                d_wait--;
                d_fire = (d_wait == 0);
            end
        end
        #1;
        imem_resp = i_fire;
        dmem_resp = d_fire;
        if (i_fire)
            imem_rdata = fetch_word(imem_addr);
        if (d_fire) begin
            if (dmem_wmask != 4'b0000)
                ram[dmem_addr[7:2]] = dmem_wdata;
            dmem_rdata = ram[dmem_addr[7:2]];
        end
    end

endmodule : rv32_mem_model

`default_nettype wire

// ==== verification/rv32_core_tb.sv ====
// ####################################################################
// Core testbench: program and store table, reset, checks, timeout.
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          mismatches = 0;
    int          faults = 0;
    int          fetches = 0;
    int          stores = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] next_fetch = '0;

    rv32_core rv32_core_i (
        .clk(clk), .arst_n(arst_n),
        .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp)
    );

    rv32_mem_model mem_i (
        .clk(clk),
        .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic op_row(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic store_row(input logic [31:0] word, input logic [31:0] a,
        input logic [31:0] d);
        prog.push_back(word);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic build_program();
        op_row(alu_imm(3'b000, 1, 0, 12'h12f));
        op_row(alu_imm(3'b000, 2, 0, 12'hffb));        // x2 = -5.
        op_row(lui(3, 20'h80000));
        op_row(alu_imm(3'b000, 4, 0, 12'd7));
        op_row(alu_reg(7'h00, 3'b000, 5, 1, 2));
        op_row(alu_reg(7'h20, 3'b000, 6, 1, 2));
        op_row(alu_reg(7'h00, 3'b111, 7, 1, 2));
        op_row(alu_reg(7'h00, 3'b110, 8, 1, 3));
        op_row(alu_reg(7'h00, 3'b100, 9, 1, 2));
        op_row(alu_reg(7'h00, 3'b010, 10, 2, 1));      // -5 is below 0x12f as signed.
        op_row(alu_reg(7'h00, 3'b011, 11, 2, 1));      // False as unsigned.
        op_row(alu_reg(7'h00, 3'b001, 12, 1, 4));
        op_row(alu_reg(7'h00, 3'b101, 13, 3, 4));
        op_row(alu_reg(7'h20, 3'b101, 14, 3, 4));
        store_row(sw(14, 0, 12'd36), 32'd36, 32'hff00_0000);
        store_row(sw(13, 0, 12'd32), 32'd32, 32'h0100_0000);
        store_row(sw(12, 0, 12'd28), 32'd28, 32'h0000_9780);
        store_row(sw(11, 0, 12'd24), 32'd24, 32'h0000_0000);
        store_row(sw(10, 0, 12'd20), 32'd20, 32'h0000_0001);
        store_row(sw(9, 0, 12'd16), 32'd16, 32'hffff_fed4);
        store_row(sw(8, 0, 12'd12), 32'd12, 32'h8000_012f);
        store_row(sw(7, 0, 12'd8), 32'd8, 32'h0000_012b);
        store_row(sw(6, 0, 12'd4), 32'd4, 32'h0000_0134);
        store_row(sw(5, 0, 12'd0), 32'd0, 32'h0000_012a);
        op_row(alu_imm(3'b100, 15, 1, 12'hfff));
        op_row(alu_imm(3'b011, 16, 1, 12'hfff));       // Immediate extends to all ones.
        op_row(alu_imm(3'b101, 17, 3, 12'h404));       // SRAI by 4.
        store_row(sw(17, 0, 12'd48), 32'd48, 32'hf800_0000);
        store_row(sw(16, 0, 12'd44), 32'd44, 32'h0000_0001);
        store_row(sw(15, 0, 12'd40), 32'd40, 32'hffff_fed0);
        op_row(alu_imm(3'b000, 0, 1, 12'd5));
        store_row(sw(0, 0, 12'd52), 32'd52, 32'h0000_0000);
        op_row(lui(23, 20'h12345));
        op_row(alu_imm(3'b000, 23, 23, 12'h678));
        op_row(alu_reg(7'h00, 3'b000, 26, 23, 23));
        op_row(alu_reg(7'h00, 3'b000, 27, 26, 23));
        op_row(alu_reg(7'h20, 3'b000, 28, 27, 23));    // x23 at distance 3.
        store_row(sw(28, 0, 12'd56), 32'd56, 32'h2468_acf0);
        store_row(sw(27, 0, 12'd60), 32'd60, 32'h369d_0368);
        store_row(sw(23, 0, 12'd64), 32'd64, 32'h1234_5678);
        op_row(lw(29, 0, 12'd64));
        op_row(alu_reg(7'h00, 3'b000, 30, 29, 4));     // Uses the load at once.
        store_row(sw(30, 0, 12'd68), 32'd68, 32'h1234_567f);
        op_row(alu_imm(3'b000, 31, 0, 12'd92));
        store_row(sw(31, 31, 12'd4), 32'd96, 32'h0000_005c);
    endtask

    task automatic check_idle_masks();
        assert (imem_rmask == 4'h0 && dmem_rmask == 4'h0 && dmem_wmask == 4'h0) else begin
            mismatches++;
            $display("MISMATCH masks: imem_rmask %h dmem_rmask %h dmem_wmask %h expected 0",
                     imem_rmask, dmem_rmask, dmem_wmask);
        end
    endtask

    task automatic wait_store();
        do
            @(negedge clk);
        while (!(dmem_resp && dmem_wmask != 4'h0));
    endtask

    task automatic print_counts();
        $display("Summary: %0d mismatches, %0d other errors, %0d stores, %0d fetches",
                 mismatches, faults, stores, fetches);
    endtask

    // Each answered fetch must be the next word address.
    always @(negedge clk) begin
        if (imem_resp) begin
            assert (imem_addr == next_fetch) else begin
                mismatches++;
                $display("MISMATCH imem_addr: got %h expected %h", imem_addr, next_fetch);
            end
            assert (imem_rmask == 4'hf) else begin
                mismatches++;
                $display("MISMATCH imem_rmask: got %h expected f", imem_rmask);
            end
            next_fetch += 4;
            fetches++;
        end
        if (dmem_resp && dmem_rmask != 4'h0) begin
            assert (dmem_rmask == 4'hf && dmem_wmask == 4'h0) else begin
                mismatches++;
                $display("MISMATCH dmem_rmask: got %h expected f (dmem_wmask %h)",
                         dmem_rmask, dmem_wmask);
            end
        end
        if (dmem_resp && dmem_wmask != 4'h0)
            stores++;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            faults++;
            $display("Timeout: program did not finish within %0d cycles", limit);
            print_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        arst_n = 1'b0;
        build_program();
        limit = (prog.size() + 8) * 10;
        foreach (prog[i])
            mem_i.load_word(i, prog[i]);
        repeat (16) @(posedge clk);
        check_idle_masks();
        #1 arst_n = 1'b1;
        #1 check_idle_masks();
        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_store();
            assert (dmem_addr == exp_addr[k]) else begin
                mismatches++;
                $display("MISMATCH dmem_addr (store %0d): got %h expected %h",
                         k, dmem_addr, exp_addr[k]);
            end
            assert (dmem_wdata == exp_data[k]) else begin
                mismatches++;
                $display("MISMATCH dmem_wdata (store %0d): got %h expected %h",
                         k, dmem_wdata, exp_data[k]);
            end
            assert (dmem_wmask == 4'hf) else begin
                mismatches++;
                $display("MISMATCH dmem_wmask (store %0d): got %h expected f", k, dmem_wmask);
            end
        end
        while (fetches < prog.size() + 6)
            @(posedge clk);
        @(posedge clk);
        assert (stores == exp_addr.size()) else begin
            faults++;
            $display("Wrong number of data writes: saw %0d, expected %0d",
                     stores, exp_addr.size());
        end
        print_counts();
        if (mismatches == 0 && faults == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule : rv32_core_tb

`default_nettype wire

// ==== rv32_core.f ====
rtl/rv32_pkg.sv
rtl/rv32_stall.sv
rtl/rv32_fetch.sv
rtl/rv32_regfile.sv
rtl/rv32_decode.sv
rtl/rv32_execute.sv
rtl/rv32_result.sv
rtl/rv32_core.sv
verification/rv32_mem_model.sv
verification/rv32_core_tb.sv
